/* Bender.yml */
package:
  name: bus_subsys

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bus_pkg.sv
      - hdl/bus_arbiter.sv
      - master/bus_master.sv
      - target/bus_target.sv
      - hdl/bus_subsys_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_bus_subsys.sv

/* bus_subsys_top.f */
+incdir+common
common/bus_pkg.sv
hdl/bus_arbiter.sv
master/bus_master.sv
target/bus_target.sv
hdl/bus_subsys_top.sv
testbench/tb_bus_subsys.sv

/* common/bus_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing and size constants of the shared bus.
// BUS_BURST_LEN must fit the 3-bit beat counter (at most 8).
// BUS_DECODE_CYCLES must be at least 1.
// BUS_TURNAROUND_CYCLES must be at least 2.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// Data beats in every burst.
`define BUS_BURST_LEN 8

// Targets on the bus, one trdy_n bit each.
`define BUS_NUM_TARGETS 2

// Cycles from the target seeing frame_n low
// to its trdy_n going low.
`define BUS_DECODE_CYCLES 2

// Cycles from trdy_n low to the first data beat.
`define BUS_TURNAROUND_CYCLES 2

`endif

/* common/bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the bus masters, arbiter and targets.
// State names carry a prefix so both FSMs fit in one package.
// Widths here must agree with the macros in bus_params.svh.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bus_pkg;

	typedef logic [7:0] byte_t;     // One data byte.
	typedef logic [8:0] beat_t;     // {rw, byte} as carried on data_c.
	typedef logic [2:0] beat_cnt_t; // Beat index and short delays.
	typedef logic       sel_t;      // Target select where 1 picks target 1.

	// Master side of one burst.
	typedef enum logic [2:0] {
		MS_IDLE,
		MS_REQUEST,    // req_n low while waiting on gnt_n.
		MS_ADDRESS,    // First cycle with frame_n low.
		MS_WAIT_TRDY,
		MS_TURNAROUND,
		MS_DATA,
		MS_RELEASE     // Bus lines back high, cmd_done pulse.
	} master_state_e;

	// Target side of one burst.
	typedef enum logic [1:0] {
		TS_IDLE,
		TS_DECODE,     // Select seen, trdy_n still high.
		TS_TURNAROUND, // trdy_n low, no data yet.
		TS_DATA
	} target_state_e;

endpackage

/* hdl/bus_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-master round-robin arbiter and shared bus multiplexer.
// A grant is held until the owner raises req_n, and the bus
// stays idle for one cycle between owners.
// With no owner the bus is parked with frame_n/irdy_n high and data_c 0.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bus_arbiter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic [1:0]     req_n,
	input  logic [1:0]     m_frame_n,
	input  logic [1:0]     m_irdy_n,
	input  logic [1:0]     m_r_sel,
	input  bus_pkg::beat_t m_data_c0,
	input  bus_pkg::beat_t m_data_c1,
	input  bus_pkg::byte_t t_data0,
	input  bus_pkg::byte_t t_data1,
	output logic [1:0]     gnt_n,
	output logic           frame_n,
	output logic           irdy_n,
	output bus_pkg::sel_t  r_sel,
	output bus_pkg::beat_t data_c,
	output bus_pkg::byte_t data_o
);

	logic busy;       // A master owns the bus.
	logic owner;      // Valid while busy.
	logic last_owner; // Owner of the previous transaction.
	logic winner;

	// When both ask, the one that did not go last wins.
	// Otherwise req_n[0] high means only master 1 is asking.
	assign winner = (req_n == 2'b00) ? ~last_owner : req_n[0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy       <= 1'b0;
			owner      <= 1'b0;
			last_owner <= 1'b1; // Master 0 goes first.
		end
		else if (!busy)
		begin
			if (req_n != 2'b11)
			begin
				busy  <= 1'b1;
				owner <= winner;
			end
		end
		else if (req_n[owner])
		begin
			// Owner is done.
			busy       <= 1'b0;
			last_owner <= owner;
		end
	end

	assign gnt_n[0] = ~(busy & ~owner);
	assign gnt_n[1] = ~(busy & owner);

	// Owner onto the shared lines.
	always_comb
	begin
		if (busy)
		begin
			frame_n = m_frame_n[owner];
			irdy_n  = m_irdy_n[owner];
			r_sel   = bus_pkg::sel_t'(m_r_sel[owner]);
			data_c  = owner ? m_data_c1 : m_data_c0;
		end
		else
		begin
			frame_n = 1'b1;
			irdy_n  = 1'b1;
			r_sel   = 1'b0;
			data_c  = '0;
		end
	end

	// Read byte back from the addressed target.
	assign data_o = r_sel ? t_data1 : t_data0;

endmodule

/* hdl/bus_subsys_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two masters, one arbiter and two targets on a shared bus.
// Each master has its own command port. A command runs one
// full burst to the target named by cmdN_target.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "bus_params.svh"

module bus_subsys_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           cmd0_valid,
	input  logic           cmd0_write,
	input  bus_pkg::sel_t  cmd0_target,
	input  bus_pkg::byte_t wdata0,
	input  logic           cmd1_valid,
	input  logic           cmd1_write,
	input  bus_pkg::sel_t  cmd1_target,
	input  bus_pkg::byte_t wdata1,
	output logic           cmd0_ready,
	output logic           wdata0_take,
	output bus_pkg::byte_t rdata0,
	output logic           rdata0_valid,
	output logic           cmd0_done,
	output logic           cmd1_ready,
	output logic           wdata1_take,
	output bus_pkg::byte_t rdata1,
	output logic           rdata1_valid,
	output logic           cmd1_done
);

	// Per-master lines into the arbiter.
	logic [1:0]     req_n;
	logic [1:0]     gnt_n;
	logic [1:0]     m_frame_n;
	logic [1:0]     m_irdy_n;
	logic [1:0]     m_r_sel;
	bus_pkg::beat_t m_data_c0;
	bus_pkg::beat_t m_data_c1;

	// Shared bus.
	logic                        frame_n;
	logic                        irdy_n;
	bus_pkg::sel_t               r_sel;
	bus_pkg::beat_t              data_c;
	bus_pkg::byte_t              data_o;
	logic [`BUS_NUM_TARGETS-1:0] trdy_n;
	bus_pkg::byte_t              t_data0;
	bus_pkg::byte_t              t_data1;

	bus_master m0 (
		.clk(clk), .rst_n(rst_n),
		.cmd_valid(cmd0_valid), .cmd_write(cmd0_write), .cmd_target(cmd0_target),
		.wdata(wdata0), .gnt_n(gnt_n[0]), .trdy_n(trdy_n), .data_o(data_o),
		.cmd_ready(cmd0_ready), .wdata_take(wdata0_take), .rdata(rdata0),
		.rdata_valid(rdata0_valid), .cmd_done(cmd0_done), .req_n(req_n[0]),
		.frame_n(m_frame_n[0]), .irdy_n(m_irdy_n[0]), .r_sel(m_r_sel[0]),
		.data_c(m_data_c0)
	);

	bus_master m1 (
		.clk(clk), .rst_n(rst_n),
		.cmd_valid(cmd1_valid), .cmd_write(cmd1_write), .cmd_target(cmd1_target),
		.wdata(wdata1), .gnt_n(gnt_n[1]), .trdy_n(trdy_n), .data_o(data_o),
		.cmd_ready(cmd1_ready), .wdata_take(wdata1_take), .rdata(rdata1),
		.rdata_valid(rdata1_valid), .cmd_done(cmd1_done), .req_n(req_n[1]),
		.frame_n(m_frame_n[1]), .irdy_n(m_irdy_n[1]), .r_sel(m_r_sel[1]),
		.data_c(m_data_c1)
	);

	bus_arbiter arb0 (
		.clk(clk), .rst_n(rst_n), .req_n(req_n),
		.m_frame_n(m_frame_n), .m_irdy_n(m_irdy_n), .m_r_sel(m_r_sel),
		.m_data_c0(m_data_c0), .m_data_c1(m_data_c1),
		.t_data0(t_data0), .t_data1(t_data1), .gnt_n(gnt_n),
		.frame_n(frame_n), .irdy_n(irdy_n), .r_sel(r_sel),
		.data_c(data_c), .data_o(data_o)
	);

	bus_target #(.TARGET_ID(0)) t0 (
		.clk(clk), .rst_n(rst_n), .frame_n(frame_n), .irdy_n(irdy_n),
		.r_sel(r_sel), .data_c(data_c), .trdy_n(trdy_n[0]), .rdata(t_data0)
	);

	bus_target #(.TARGET_ID(1)) t1 (
		.clk(clk), .rst_n(rst_n), .frame_n(frame_n), .irdy_n(irdy_n),
		.r_sel(r_sel), .data_c(data_c), .trdy_n(trdy_n[1]), .rdata(t_data1)
	);

endmodule

/* master/bus_master.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst master. One accepted command becomes one full burst.
// Write bytes are pulled with wdata_take one cycle ahead of
// each beat. Read bytes are valid only while rdata_valid is
// high and have no back-pressure.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "bus_params.svh"

module bus_master (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        cmd_valid,
	input  logic                        cmd_write,
	input  bus_pkg::sel_t               cmd_target,
	input  bus_pkg::byte_t              wdata,
	input  logic                        gnt_n,
	input  logic [`BUS_NUM_TARGETS-1:0] trdy_n,
	input  bus_pkg::byte_t              data_o,
	output logic                        cmd_ready,
	output logic                        wdata_take,
	output bus_pkg::byte_t              rdata,
	output logic                        rdata_valid,
	output logic                        cmd_done,
	output logic                        req_n,
	output logic                        frame_n,
	output logic                        irdy_n,
	output bus_pkg::sel_t               r_sel,
	output bus_pkg::beat_t              data_c
);

	bus_pkg::master_state_e state;
	bus_pkg::beat_cnt_t     cnt;     // Turnaround delay, then beat index.
	logic                   write_q; // Direction of the current command.
	bus_pkg::sel_t          sel_q;   // Target of the current command.
	logic                   last_turn;
	logic                   last_beat;

	assign last_turn = (cnt == bus_pkg::beat_cnt_t'(`BUS_TURNAROUND_CYCLES - 2));
	assign last_beat = (cnt == bus_pkg::beat_cnt_t'(`BUS_BURST_LEN - 1));

	// Command latch.
	always_ff @(posedge clk)
	begin
		if (state == bus_pkg::MS_IDLE && cmd_valid)
		begin
			write_q <= cmd_write;
			sel_q   <= cmd_target;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= bus_pkg::MS_IDLE;
			cnt     <= '0;
			req_n   <= 1'b1;
			frame_n <= 1'b1;
			irdy_n  <= 1'b1;
			data_c  <= '0;
		end
		else
		begin
			case (state)
				bus_pkg::MS_IDLE:
					if (cmd_valid)
					begin
						req_n <= 1'b0;
						state <= bus_pkg::MS_REQUEST;
					end
				bus_pkg::MS_REQUEST:
					if (!gnt_n)
					begin
						frame_n <= 1'b0;
						irdy_n  <= 1'b0;
						state   <= bus_pkg::MS_ADDRESS;
					end
				bus_pkg::MS_ADDRESS:
					state <= bus_pkg::MS_WAIT_TRDY;
				bus_pkg::MS_WAIT_TRDY:
					if (!trdy_n[sel_q])
					begin
						cnt   <= '0;
						state <= bus_pkg::MS_TURNAROUND;
					end
				bus_pkg::MS_TURNAROUND:
					if (last_turn)
					begin
						cnt    <= '0;
						data_c <= {write_q, write_q ? wdata : 8'h00}; // First beat.
						state  <= bus_pkg::MS_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				bus_pkg::MS_DATA:
					if (last_beat)
					begin
						data_c  <= '0;
						req_n   <= 1'b1;
						frame_n <= 1'b1;
						irdy_n  <= 1'b1;
						state   <= bus_pkg::MS_RELEASE;
					end
					else
					begin
						cnt    <= cnt + 1'b1;
						data_c <= {write_q, write_q ? wdata : 8'h00};
					end
				bus_pkg::MS_RELEASE:
					state <= bus_pkg::MS_IDLE;
				default:
					state <= bus_pkg::MS_IDLE;
			endcase
		end
	end

	assign cmd_ready = (state == bus_pkg::MS_IDLE);
	assign cmd_done  = (state == bus_pkg::MS_RELEASE);
	assign r_sel     = sel_q;

	// Byte for the next beat is taken on this edge.
	assign wdata_take = write_q &&
		((state == bus_pkg::MS_TURNAROUND && last_turn) ||
		 (state == bus_pkg::MS_DATA && !last_beat));

	// Read data is live during the beat cycles only.
	assign rdata_valid = !write_q && (state == bus_pkg::MS_DATA);
	assign rdata       = rdata_valid ? data_o : 8'h00;

endmodule

/* target/bus_target.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus target with one burst buffer and no address decode.
// A read returns the last burst written here, zeros after reset.
// Direction is taken per beat from bit 8 of data_c.
// TARGET_ID is 0 or 1 and is matched against r_sel.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "bus_params.svh"

module bus_target #(
	parameter int TARGET_ID = 0
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           frame_n,
	input  logic           irdy_n,
	input  bus_pkg::sel_t  r_sel,
	input  bus_pkg::beat_t data_c,
	output logic           trdy_n,
	output bus_pkg::byte_t rdata
);

	bus_pkg::target_state_e state;
	bus_pkg::beat_cnt_t     cnt;
	bus_pkg::byte_t         buffer [`BUS_BURST_LEN];
	logic                   selected;
	logic                   last_decode;
	logic                   last_turn;
	logic                   last_beat;

	assign selected    = !frame_n && !irdy_n && (r_sel == bus_pkg::sel_t'(TARGET_ID));
	assign last_decode = (cnt == bus_pkg::beat_cnt_t'(`BUS_DECODE_CYCLES - 1));
	assign last_turn   = (cnt == bus_pkg::beat_cnt_t'(`BUS_TURNAROUND_CYCLES - 1));
	assign last_beat   = (cnt == bus_pkg::beat_cnt_t'(`BUS_BURST_LEN - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state  <= bus_pkg::TS_IDLE;
			cnt    <= '0;
			trdy_n <= 1'b1;
		end
		else
		begin
			case (state)
				bus_pkg::TS_IDLE:
					if (selected)
					begin
						cnt   <= '0;
						state <= bus_pkg::TS_DECODE;
					end
				bus_pkg::TS_DECODE:
					if (last_decode)
					begin
						cnt    <= '0;
						trdy_n <= 1'b0;
						state  <= bus_pkg::TS_TURNAROUND;
					end
					else
						cnt <= cnt + 1'b1;
				bus_pkg::TS_TURNAROUND:
					if (last_turn)
					begin
						cnt   <= '0;
						state <= bus_pkg::TS_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				bus_pkg::TS_DATA:
					if (last_beat)
					begin
						trdy_n <= 1'b1; // Master raises frame_n on the same edge.
						state  <= bus_pkg::TS_IDLE;
					end
					else
						cnt <= cnt + 1'b1;
				default:
					state <= bus_pkg::TS_IDLE;
			endcase
		end
	end

	// Burst buffer, one entry per beat.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `BUS_BURST_LEN; i++)
				buffer[i] <= 8'h00;
		end
		else if (state == bus_pkg::TS_DATA && !irdy_n && data_c[8])
			buffer[cnt] <= data_c[7:0];
	end

	// Read byte for the current beat.
	assign rdata = (state == bus_pkg::TS_DATA && !data_c[8]) ? buffer[cnt] : 8'h00;

endmodule

/* testbench/tb_bus_subsys.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random-stimulus testbench for bus_subsys_top.
// Bursts on the shared bus never overlap, so a read is predicted
// from the buffer model at the first cycle of its data phase.
// Every wait is bounded by WAIT_LIMIT cycles per command.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "bus_params.svh"

module tb_bus_subsys;

	localparam int WAIT_LIMIT = 200; // Grant wait included.

	logic           clk;
	logic           rst_n;
	logic           cmd0_valid;
	logic           cmd0_write;
	bus_pkg::sel_t  cmd0_target;
	bus_pkg::byte_t wdata0;
	logic           cmd1_valid;
	logic           cmd1_write;
	bus_pkg::sel_t  cmd1_target;
	bus_pkg::byte_t wdata1;
	logic           cmd0_ready;
	logic           wdata0_take;
	bus_pkg::byte_t rdata0;
	logic           rdata0_valid;
	logic           cmd0_done;
	logic           cmd1_ready;
	logic           wdata1_take;
	bus_pkg::byte_t rdata1;
	logic           rdata1_valid;
	logic           cmd1_done;

	logic [31:0] rng_state;
	logic [63:0] model_mem [2]; // One 8-byte burst per target.
	int          error_count;
	int          tests_failed;
	bit          hung;

	bus_subsys_top dut0 (
		.clk(clk), .rst_n(rst_n),
		.cmd0_valid(cmd0_valid), .cmd0_write(cmd0_write), .cmd0_target(cmd0_target),
		.wdata0(wdata0), .cmd1_valid(cmd1_valid), .cmd1_write(cmd1_write),
		.cmd1_target(cmd1_target), .wdata1(wdata1),
		.cmd0_ready(cmd0_ready), .wdata0_take(wdata0_take), .rdata0(rdata0),
		.rdata0_valid(rdata0_valid), .cmd0_done(cmd0_done),
		.cmd1_ready(cmd1_ready), .wdata1_take(wdata1_take), .rdata1(rdata1),
		.rdata1_valid(rdata1_valid), .cmd1_done(cmd1_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic drive_inputs(input int m, input logic valid, input logic wr,
		input bus_pkg::sel_t tgt, input bus_pkg::byte_t wd);
		if (m == 0)
		begin
			cmd0_valid  <= valid;
			cmd0_write  <= wr;
			cmd0_target <= tgt;
			wdata0      <= wd;
		end
		else
		begin
			cmd1_valid  <= valid;
			cmd1_write  <= wr;
			cmd1_target <= tgt;
			wdata1      <= wd;
		end
	endtask

	task automatic sample_outputs(input int m, output logic ready, output logic take,
		output logic rvalid, output bus_pkg::byte_t rbyte, output logic done);
		ready  = m ? cmd1_ready : cmd0_ready;
		take   = m ? wdata1_take : wdata0_take;
		rvalid = m ? rdata1_valid : rdata0_valid;
		rbyte  = m ? rdata1 : rdata0;
		done   = m ? cmd1_done : cmd0_done;
	endtask

	// Data phase of one accepted command, up to cmd_done.
	task automatic follow_burst(input int m, input logic wr, input bus_pkg::sel_t tgt,
		input logic [63:0] wbytes, output logic [63:0] rbytes);
		int             cycles;
		int             takes;
		int             beats;
		bit             valid_ended;
		logic           ready;
		logic           take;
		logic           rvalid;
		logic           done;
		bus_pkg::byte_t rbyte;
		logic [63:0]    expected;

		rbytes      = '0;
		expected    = '0;
		cycles      = 0;
		takes       = 0;
		beats       = 0;
		valid_ended = 1'b0;
		done        = 1'b0;
		while (!done && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			sample_outputs(m, ready, take, rvalid, rbyte, done);
			if (take)
				takes++;
			if (rvalid)
			begin
				if (beats == 0)
					expected = model_mem[tgt]; // Snapshot at the first beat.
				if (wr || valid_ended || beats >= `BUS_BURST_LEN)
				begin
					$display("%0t: master %0d shows rdata_valid outside a read data phase",
						$time, m);
					error_count++;
				end
				else
				begin
					if (rbyte !== expected[8*beats +: 8])
					begin
						$display("Mismatch at %0t: master %0d beat %0d expected %02h actual %02h",
							$time, m, beats, expected[8*beats +: 8], rbyte);
						error_count++;
					end
					rbytes[8*beats +: 8] = rbyte;
				end
				beats++;
			end
			else if (beats > 0)
				valid_ended = 1'b1;
			@(posedge clk);
			if (take && takes < `BUS_BURST_LEN)
				drive_inputs(m, 1'b0, wr, tgt, wbytes[8*takes +: 8]);
			cycles++;
		end
		if (!done)
		begin
			$display("%0t: master %0d did not finish its burst in time", $time, m);
			error_count++;
			hung = 1'b1;
		end
		else if (wr)
		begin
			if (takes != `BUS_BURST_LEN)
			begin
				$display("%0t: master %0d took %0d write bytes instead of 8", $time, m, takes);
				error_count++;
			end
			model_mem[tgt] = wbytes;
		end
		else if (beats != `BUS_BURST_LEN || takes != 0)
		begin
			$display("%0t: master %0d read showed %0d valid beats and %0d byte takes",
				$time, m, beats, takes);
			error_count++;
		end
	endtask

	task automatic run_command(input int m, input logic wr, input bus_pkg::sel_t tgt,
		input logic [63:0] wbytes, output logic [63:0] rbytes);
		int             cycles;
		logic           ready;
		logic           take;
		logic           rvalid;
		logic           done;
		bus_pkg::byte_t rbyte;

		cycles = 0;
		ready  = 1'b0;
		rbytes = '0;
		@(posedge clk);
		drive_inputs(m, 1'b1, wr, tgt, wbytes[7:0]);
		while (!ready && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			sample_outputs(m, ready, take, rvalid, rbyte, done);
			@(posedge clk);
			cycles++;
		end
		drive_inputs(m, 1'b0, wr, tgt, wbytes[7:0]); // Handshake edge just passed.
		if (!ready)
		begin
			$display("%0t: master %0d never raised cmd_ready", $time, m);
			error_count++;
			hung = 1'b1;
		end
		else
			follow_burst(m, wr, tgt, wbytes, rbytes);
	endtask

	task automatic check_idle(input int m);
		logic           ready;
		logic           take;
		logic           rvalid;
		logic           done;
		bus_pkg::byte_t rbyte;

		sample_outputs(m, ready, take, rvalid, rbyte, done);
		if (ready !== 1'b1 || take !== 1'b0 || rvalid !== 1'b0 || done !== 1'b0)
		begin
			$display("%0t: master %0d is not idle after reset", $time, m);
			error_count++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		if (error_count != err_start)
		begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name,
				error_count - err_start);
		end
		else if (hung)
		begin
			tests_failed++;
			$display("test %0d %s: skipped after a timeout", num, name);
		end
		else
			$display("test %0d %s: passed", num, name);
	endtask

	initial
	begin
		logic [31:0] r;
		logic [63:0] burst_a;
		logic [63:0] burst_b;
		logic [63:0] rd_a;
		logic [63:0] rd_b;
		int          err_start;

		rng_state    = 32'hfc4708db;
		model_mem[0] = '0;
		model_mem[1] = '0;
		error_count  = 0;
		tests_failed = 0;
		hung         = 1'b0;
		rst_n        = 1'b0;
		cmd0_valid   = 1'b0;
		cmd0_write   = 1'b0;
		cmd0_target  = 1'b0;
		wdata0       = 8'h00;
		cmd1_valid   = 1'b0;
		cmd1_write   = 1'b0;
		cmd1_target  = 1'b0;
		wdata1       = 8'h00;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// Idle outputs, then zero buffers.
		err_start = error_count;
		@(negedge clk);
		check_idle(0);
		check_idle(1);
		run_command(0, 1'b0, 1'b0, '0, rd_a);
		if (!hung)
			run_command(1, 1'b0, 1'b1, '0, rd_b);
		report_test(1, "reset state", err_start);

		err_start = error_count;
		if (!hung)
		begin
			r       = next_random();
			burst_a = {next_random(), next_random()};
			run_command(0, 1'b1, r[0], burst_a, rd_a);
			run_command(0, 1'b0, r[0], '0, rd_a);
			if (!hung && rd_a !== burst_a)
			begin
				$display("Mismatch at %0t: read back %h, written %h", $time, rd_a, burst_a);
				error_count++;
			end
		end
		report_test(2, "write then read", err_start);

		err_start = error_count;
		if (!hung)
		begin
			burst_a = {next_random(), next_random()};
			burst_b = {next_random(), next_random()};
			run_command(0, 1'b1, 1'b0, burst_a, rd_a);
			run_command(1, 1'b1, 1'b1, burst_b, rd_b);
			run_command(1, 1'b0, 1'b0, '0, rd_a);
			run_command(0, 1'b0, 1'b1, '0, rd_b);
		end
		report_test(3, "target independence", err_start);

		// Odd rounds aim both masters at the same target.
		err_start = error_count;
		for (int i = 0; i < 8 && !hung; i++)
		begin
			r       = next_random();
			burst_a = {next_random(), next_random()};
			burst_b = {next_random(), next_random()};
			fork
				run_command(0, r[1], r[0], burst_a, rd_a);
				run_command(1, r[2], i[0] ? r[0] : ~r[0], burst_b, rd_b);
			join
		end
		report_test(4, "concurrent masters", err_start);

		err_start = error_count;
		for (int m = 0; m < 2 && !hung; m++)
		begin
			r       = next_random();
			burst_a = {next_random(), next_random()};
			run_command(m, 1'b1, r[0], burst_a, rd_a);
			run_command(m, 1'b0, r[0], '0, rd_a);
		end
		report_test(5, "data phase shape", err_start);

		// 100 rounds of one command per master.
		err_start = error_count;
		for (int i = 0; i < 100 && !hung; i++)
		begin
			r       = next_random();
			burst_a = {next_random(), next_random()};
			burst_b = {next_random(), next_random()};
			if (r[0])
			begin
				fork
					run_command(0, r[1], r[3], burst_a, rd_a);
					run_command(1, r[2], r[4], burst_b, rd_b);
				join
			end
			else
			begin
				run_command(0, r[1], r[3], burst_a, rd_a);
				run_command(1, r[2], r[4], burst_b, rd_b);
			end
		end
		report_test(6, "random soak", err_start);

		$display("tests run: 6, tests failed: %0d, errors: %0d", tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
